/* Makefile */
# Verilator build and run for the RV32I pipeline core
TOP ?= coreTb
SEED ?= 1
LOG ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
FILELIST ?= vlog.f
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard common/*.sv source/*.sv pipeline/*.sv tests/*.sv tests/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  parameter int dataWidth = 32;
  parameter int regIndexWidth = 5;

  // Major opcodes of the supported RV32I subset
  parameter logic [6:0] opcodeOp = 7'b0110011;
  parameter logic [6:0] opcodeOpImm = 7'b0010011;
  parameter logic [6:0] opcodeLui = 7'b0110111;
  parameter logic [6:0] opcodeLoad = 7'b0000011;
  parameter logic [6:0] opcodeStore = 7'b0100011;
  parameter logic [6:0] opcodeBranch = 7'b1100011;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr = 4'd3,
    aluXor = 4'd4,
    aluSlt = 4'd5,
    aluPassB = 4'd6
  } aluOpT;

  // Same word, four field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rType;
    struct packed {
      logic [11:0] imm12;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } iType;
    struct packed {
      logic [6:0] immHigh;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLow;
      logic [6:0] opcode;
    } sType;
    struct packed {
      logic immBit12;
      logic [5:0] immHigh;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] immLow;
      logic immBit11;
      logic [6:0] opcode;
    } bType;
  } instrT;

endpackage

`default_nettype wire

/* pipeline/decodeStage.sv */
`default_nettype none
`timescale 1ns/1ns

module decodeStage
  import cpuPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  instrT instruction,
  input  logic [dataWidth-1:0] pc,
  input  logic [dataWidth-1:0] rs1Data,
  input  logic [dataWidth-1:0] rs2Data,
  input  logic stall,
  input  logic freeze,
  input  logic flush,
  output logic [dataWidth-1:0] exPc,
  output logic [dataWidth-1:0] exRs1Data,
  output logic [dataWidth-1:0] exRs2Data,
  output logic [dataWidth-1:0] exImmediate,
  output logic [regIndexWidth-1:0] exRs1,
  output logic [regIndexWidth-1:0] exRs2,
  output logic [regIndexWidth-1:0] exRd,
  output aluOpT exAluOp,
  output logic exAluSrc,
  output logic exMemRead,
  output logic exMemWrite,
  output logic exRegWrite,
  output logic exMemToReg,
  output logic exBranch,
  output logic exBranchNotEqual
);

  logic [dataWidth-1:0] immediate;
  logic [regIndexWidth-1:0] rs1;
  logic [regIndexWidth-1:0] rs2;
  logic [regIndexWidth-1:0] rd;
  aluOpT aluOp;
  logic aluSrc;
  logic memRead;
  logic memWrite;
  logic regWrite;
  logic memToReg;
  logic branch;
  logic branchNotEqual;
  logic insertBubble;

  function automatic aluOpT aluFromFunct3(input logic [2:0] funct3, input logic subtract);
    aluOpT op;
    case (funct3)
      3'b000: op = subtract ? aluSub : aluAdd;
      3'b010: op = aluSlt;
      3'b100: op = aluXor;
      3'b110: op = aluOr;
      3'b111: op = aluAnd;
      default: op = aluAdd;
    endcase
    return op;
  endfunction

  always_comb begin
    immediate = '0;
    rs1 = '0;
    rs2 = '0;
    rd = '0;
    aluOp = aluAdd;
    aluSrc = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    regWrite = 1'b0;
    memToReg = 1'b0;
    branch = 1'b0;
    branchNotEqual = 1'b0;
    case (instruction.rType.opcode)
      opcodeOp: begin
        rs1 = instruction.rType.rs1;
        rs2 = instruction.rType.rs2;
        rd = instruction.rType.rd;
        aluOp = aluFromFunct3(instruction.rType.funct3, instruction.rType.funct7[5]);
        regWrite = 1'b1;
      end
      opcodeOpImm, opcodeLoad: begin
        rs1 = instruction.iType.rs1;
        rd = instruction.iType.rd;
        immediate = {{20{instruction.iType.imm12[11]}}, instruction.iType.imm12};
        aluSrc = 1'b1;
        regWrite = 1'b1;
        if (instruction.iType.opcode == opcodeLoad) begin
          memRead = 1'b1;
          memToReg = 1'b1;
        end else begin
          aluOp = aluFromFunct3(instruction.iType.funct3, 1'b0);
        end
      end
      opcodeLui: begin
        rd = instruction.rType.rd;
        // U immediate spans everything above rd
        immediate = {instruction.rType.funct7, instruction.rType.rs2, instruction.rType.rs1,
                     instruction.rType.funct3, 12'b0};
        aluOp = aluPassB;
        aluSrc = 1'b1;
        regWrite = 1'b1;
      end
      opcodeStore: begin
        rs1 = instruction.sType.rs1;
        rs2 = instruction.sType.rs2;
        immediate = {{20{instruction.sType.immHigh[6]}}, instruction.sType.immHigh,
                     instruction.sType.immLow};
        aluSrc = 1'b1;
        memWrite = 1'b1;
      end
      opcodeBranch: begin
        rs1 = instruction.bType.rs1;
        rs2 = instruction.bType.rs2;
        immediate = {{19{instruction.bType.immBit12}}, instruction.bType.immBit12,
                     instruction.bType.immBit11, instruction.bType.immHigh,
                     instruction.bType.immLow, 1'b0};
        aluOp = aluSub;
        branch = 1'b1;
        branchNotEqual = instruction.bType.funct3[0];
      end
      default: begin
      end
    endcase
  end

  assign insertBubble = stall || flush;

  // ID/EX control
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exRs1 <= '0;
      exRs2 <= '0;
      exRd <= '0;
      exAluOp <= aluAdd;
      exAluSrc <= 1'b0;
      exMemRead <= 1'b0;
      exMemWrite <= 1'b0;
      exRegWrite <= 1'b0;
      exMemToReg <= 1'b0;
      exBranch <= 1'b0;
      exBranchNotEqual <= 1'b0;
    end else if (!freeze) begin
      exRs1 <= insertBubble ? '0 : rs1;
      exRs2 <= insertBubble ? '0 : rs2;
      exRd <= insertBubble ? '0 : rd;
      exAluOp <= insertBubble ? aluAdd : aluOp;
      exAluSrc <= !insertBubble && aluSrc;
      exMemRead <= !insertBubble && memRead;
      exMemWrite <= !insertBubble && memWrite;
      exRegWrite <= !insertBubble && regWrite;
      exMemToReg <= !insertBubble && memToReg;
      exBranch <= !insertBubble && branch;
      exBranchNotEqual <= !insertBubble && branchNotEqual;
    end
  end

  // ID/EX operands
  always_ff @(posedge clk) begin
    if (!freeze) begin
      exPc <= pc;
      exRs1Data <= rs1Data;
      exRs2Data <= rs2Data;
      exImmediate <= immediate;
    end
  end

endmodule

`default_nettype wire

/* pipeline/executeStage.sv */
`default_nettype none
`timescale 1ns/1ns

module executeStage
  import cpuPkg::*;
(
  input  logic [dataWidth-1:0] exPc,
  input  logic [dataWidth-1:0] exRs1Data,
  input  logic [dataWidth-1:0] exRs2Data,
  input  logic [dataWidth-1:0] exImmediate,
  input  logic [regIndexWidth-1:0] exRs1,
  input  logic [regIndexWidth-1:0] exRs2,
  input  aluOpT exAluOp,
  input  logic exAluSrc,
  input  logic exBranch,
  input  logic exBranchNotEqual,
  input  logic [regIndexWidth-1:0] memRd,
  input  logic memRegWrite,
  input  logic [dataWidth-1:0] memAluResult,
  input  logic [regIndexWidth-1:0] wbRd,
  input  logic wbRegWrite,
  input  logic [dataWidth-1:0] wbData,
  output logic [dataWidth-1:0] aluResult,
  output logic [dataWidth-1:0] storeData,
  output logic branchTaken,
  output logic [dataWidth-1:0] branchTarget
);

  logic [dataWidth-1:0] operandA;
  logic [dataWidth-1:0] forwardedB;
  logic [dataWidth-1:0] operandB;
  logic lessThan;
  logic operandsEqual;

  // Youngest producer wins; x0 is never forwarded
  function automatic logic [dataWidth-1:0] forwardOperand(
    input logic [regIndexWidth-1:0] index,
    input logic [dataWidth-1:0] registerValue,
    input logic [regIndexWidth-1:0] memIndex,
    input logic memWrite,
    input logic [dataWidth-1:0] memValue,
    input logic [regIndexWidth-1:0] wbIndex,
    input logic wbWrite,
    input logic [dataWidth-1:0] wbValue
  );
    logic [dataWidth-1:0] value;
    if (index != '0 && memWrite && memIndex == index) begin
      value = memValue;
    end else if (index != '0 && wbWrite && wbIndex == index) begin
      value = wbValue;
    end else begin
      value = registerValue;
    end
    return value;
  endfunction

  assign operandA = forwardOperand(exRs1, exRs1Data, memRd, memRegWrite, memAluResult,
                                   wbRd, wbRegWrite, wbData);
  assign forwardedB = forwardOperand(exRs2, exRs2Data, memRd, memRegWrite, memAluResult,
                                     wbRd, wbRegWrite, wbData);

  assign operandB = exAluSrc ? exImmediate : forwardedB;

  // Store data bypasses the immediate mux
  assign storeData = forwardedB;

  assign lessThan = $signed(operandA) < $signed(operandB);

  always_comb begin
    case (exAluOp)
      aluAdd: aluResult = operandA + operandB;
      aluSub: aluResult = operandA - operandB;
      aluAnd: aluResult = operandA & operandB;
      aluOr: aluResult = operandA | operandB;
      aluXor: aluResult = operandA ^ operandB;
      aluSlt: aluResult = {{(dataWidth - 1){1'b0}}, lessThan};
      aluPassB: aluResult = operandB;
      default: aluResult = operandA + operandB;
    endcase
  end

  // BEQ and BNE compare the forwarded registers directly
  assign operandsEqual = operandA == forwardedB;
  assign branchTaken = exBranch && (operandsEqual ^ exBranchNotEqual);
  assign branchTarget = exPc + exImmediate;

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`default_nettype none
`timescale 1ns/1ns

module hazardUnit
  import cpuPkg::*;
(
  input  logic [regIndexWidth-1:0] idRs1,
  input  logic [regIndexWidth-1:0] idRs2,
  input  logic [regIndexWidth-1:0] exRd,
  input  logic exMemRead,
  input  logic instrReady,
  input  logic memAccess,
  input  logic dataReady,
  output logic stall,
  output logic freeze
);

  logic loadUse;
  logic fetchWait;

  // Load result is not ready until it leaves the memory stage
  assign loadUse = exMemRead && exRd != '0 && (exRd == idRs1 || exRd == idRs2);

  assign fetchWait = !instrReady;

  assign stall = loadUse || fetchWait;

  // Whole pipeline waits on an outstanding data access
  assign freeze = memAccess && !dataReady;

endmodule

`default_nettype wire

/* source/registerFile.sv */
`default_nettype none
`timescale 1ns/1ns

module registerFile
  import cpuPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic [regIndexWidth-1:0] rs1,
  input  logic [regIndexWidth-1:0] rs2,
  input  logic [regIndexWidth-1:0] rd,
  input  logic [dataWidth-1:0] writeData,
  input  logic writeEnable,
  output logic [dataWidth-1:0] rs1Data,
  output logic [dataWidth-1:0] rs2Data
);

  localparam int regCount = 2 ** regIndexWidth;

  // x0 has no storage
  logic [dataWidth-1:0] registers [1:regCount-1];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < regCount; i++) begin
        registers[i] <= '0;
      end
    end else if (writeEnable && rd != '0) begin
      registers[rd] <= writeData;
    end
  end

  // Writeback bypass so decode sees this cycle's write
  assign rs1Data = (rs1 == '0) ? '0 :
                   (writeEnable && rd == rs1) ? writeData : registers[rs1];
  assign rs2Data = (rs2 == '0) ? '0 :
                   (writeEnable && rd == rs2) ? writeData : registers[rs2];

endmodule

`default_nettype wire

/* source/riscvCore.sv */
`default_nettype none
`timescale 1ns/1ns

module riscvCore
  import cpuPkg::*;
#(
  parameter logic [31:0] resetAddress = 32'h0000_0000
) (
  input  logic clk,
  input  logic rstN,
  output logic [31:0] instrAddress,
  input  logic [31:0] instrData,
  input  logic instrReady,
  output logic [31:0] dataAddress,
  output logic [31:0] dataWriteData,
  output logic dataRead,
  output logic dataWrite,
  input  logic [31:0] dataReadData,
  input  logic dataReady
);

  logic [dataWidth-1:0] pc;
  instrT ifIdInstr;
  logic [dataWidth-1:0] ifIdPc;
  logic [dataWidth-1:0] rs1Data;
  logic [dataWidth-1:0] rs2Data;
  logic stall;
  logic freeze;

  logic [dataWidth-1:0] exPc;
  logic [dataWidth-1:0] exRs1Data;
  logic [dataWidth-1:0] exRs2Data;
  logic [dataWidth-1:0] exImmediate;
  logic [regIndexWidth-1:0] exRs1;
  logic [regIndexWidth-1:0] exRs2;
  logic [regIndexWidth-1:0] exRd;
  aluOpT exAluOp;
  logic exAluSrc;
  logic exMemRead;
  logic exMemWrite;
  logic exRegWrite;
  logic exMemToReg;
  logic exBranch;
  logic exBranchNotEqual;
  logic [dataWidth-1:0] aluResult;
  logic [dataWidth-1:0] storeData;
  logic branchTaken;
  logic [dataWidth-1:0] branchTarget;

  logic [dataWidth-1:0] memAluResult;
  logic [dataWidth-1:0] memStoreData;
  logic [regIndexWidth-1:0] memRd;
  logic memMemRead;
  logic memMemWrite;
  logic memRegWrite;
  logic memMemToReg;

  logic [dataWidth-1:0] wbAluResult;
  logic [dataWidth-1:0] wbLoadData;
  logic [regIndexWidth-1:0] wbRd;
  logic wbRegWrite;
  logic wbMemToReg;
  logic [dataWidth-1:0] wbData;

  // Redirect beats a fetch stall, freeze beats both
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= resetAddress;
    end else if (!freeze) begin
      if (branchTaken) begin
        pc <= branchTarget;
      end else if (!stall) begin
        pc <= pc + 32'd4;
      end
    end
  end

  assign instrAddress = pc;

  // All-zero word decodes as a bubble
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifIdInstr <= '0;
    end else if (!freeze) begin
      if (branchTaken) begin
        ifIdInstr <= '0;
      end else if (!stall) begin
        ifIdInstr <= instrData;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze && !stall) begin
      ifIdPc <= pc;
    end
  end

  registerFile registerFileInst (
    .clk(clk),
    .rstN(rstN),
    .rs1(ifIdInstr.rType.rs1),
    .rs2(ifIdInstr.rType.rs2),
    .rd(wbRd),
    .writeData(wbData),
    .writeEnable(wbRegWrite),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data)
  );

  hazardUnit hazardUnitInst (
    .idRs1(ifIdInstr.rType.rs1),
    .idRs2(ifIdInstr.rType.rs2),
    .exRd(exRd),
    .exMemRead(exMemRead),
    .instrReady(instrReady),
    .memAccess(memMemRead || memMemWrite),
    .dataReady(dataReady),
    .stall(stall),
    .freeze(freeze)
  );

  decodeStage decodeStageInst (
    .clk(clk),
    .rstN(rstN),
    .instruction(ifIdInstr),
    .pc(ifIdPc),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .stall(stall),
    .freeze(freeze),
    .flush(branchTaken),
    .exPc(exPc),
    .exRs1Data(exRs1Data),
    .exRs2Data(exRs2Data),
    .exImmediate(exImmediate),
    .exRs1(exRs1),
    .exRs2(exRs2),
    .exRd(exRd),
    .exAluOp(exAluOp),
    .exAluSrc(exAluSrc),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exRegWrite(exRegWrite),
    .exMemToReg(exMemToReg),
    .exBranch(exBranch),
    .exBranchNotEqual(exBranchNotEqual)
  );

  executeStage executeStageInst (
    .exPc(exPc),
    .exRs1Data(exRs1Data),
    .exRs2Data(exRs2Data),
    .exImmediate(exImmediate),
    .exRs1(exRs1),
    .exRs2(exRs2),
    .exAluOp(exAluOp),
    .exAluSrc(exAluSrc),
    .exBranch(exBranch),
    .exBranchNotEqual(exBranchNotEqual),
    .memRd(memRd),
    .memRegWrite(memRegWrite),
    .memAluResult(memAluResult),
    .wbRd(wbRd),
    .wbRegWrite(wbRegWrite),
    .wbData(wbData),
    .aluResult(aluResult),
    .storeData(storeData),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget)
  );

  // EX/MEM
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memRd <= '0;
      memMemRead <= 1'b0;
      memMemWrite <= 1'b0;
      memRegWrite <= 1'b0;
      memMemToReg <= 1'b0;
    end else if (!freeze) begin
      memRd <= exRd;
      memMemRead <= exMemRead;
      memMemWrite <= exMemWrite;
      memRegWrite <= exRegWrite;
      memMemToReg <= exMemToReg;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      memAluResult <= aluResult;
      memStoreData <= storeData;
    end
  end

  assign dataAddress = memAluResult;
  assign dataWriteData = memStoreData;
  assign dataRead = memMemRead;
  assign dataWrite = memMemWrite;

  // MEM/WB; load data lands here in the accept cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbRd <= '0;
      wbRegWrite <= 1'b0;
      wbMemToReg <= 1'b0;
    end else if (!freeze) begin
      wbRd <= memRd;
      wbRegWrite <= memRegWrite;
      wbMemToReg <= memMemToReg;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      wbAluResult <= memAluResult;
      wbLoadData <= dataReadData;
    end
  end

  assign wbData = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

`default_nettype wire

/* tests/riscvModel.svh */
`ifndef RISCV_MODEL_SVH
`define RISCV_MODEL_SVH

localparam int programWords = 64;
// BEQ x0, x0, 0
localparam logic [31:0] loopWord = 32'h0000_0063;

logic [31:0] programImage [0:programWords-1];
logic [31:0] expectedAddress [$];
logic [31:0] expectedData [$];

function automatic logic [31:0] encodeR(input logic [2:0] funct3, input bit subtract,
                                        input int rd, input int rs1, input int rs2);
  return {1'b0, subtract, 5'b0, rs2[4:0], rs1[4:0], funct3, rd[4:0], opcodeOp};
endfunction

function automatic logic [31:0] encodeI(input logic [6:0] opcode, input logic [2:0] funct3,
                                        input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
endfunction

function automatic logic [31:0] encodeS(input int rs2, input int rs1, input int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opcodeStore};
endfunction

function automatic logic [31:0] encodeB(input logic [2:0] funct3, input int rs1, input int rs2,
                                        input int imm);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3, imm[4:1], imm[11], opcodeBranch};
endfunction

function automatic logic [31:0] encodeU(input int rd, input int upper);
  return {upper[19:0], rd[4:0], opcodeLui};
endfunction

function automatic void loadProgram();
  programImage = '{default: '0};
  programImage[0] = encodeI(opcodeOpImm, 3'b000, 1, 0, 'h123);
  programImage[1] = encodeI(opcodeOpImm, 3'b000, 2, 0, -5);
  programImage[2] = encodeU(3, 'hABCDE);
  programImage[3] = encodeI(opcodeOpImm, 3'b000, 10, 0, 'h200);
  // Dependent chain, each result used by the next one or two
  programImage[4] = encodeR(3'b000, 1'b0, 4, 1, 2);
  programImage[5] = encodeR(3'b000, 1'b1, 5, 4, 1);
  programImage[6] = encodeR(3'b111, 1'b0, 6, 5, 3);
  programImage[7] = encodeR(3'b110, 1'b0, 7, 6, 4);
  programImage[8] = encodeR(3'b100, 1'b0, 8, 7, 6);
  programImage[9] = encodeR(3'b010, 1'b0, 9, 2, 1);
  programImage[10] = encodeS(9, 10, 0);
  programImage[11] = encodeS(4, 10, 4);
  programImage[12] = encodeS(5, 10, 8);
  programImage[13] = encodeS(6, 10, 12);
  programImage[14] = encodeS(7, 10, 16);
  programImage[15] = encodeS(8, 10, 20);
  programImage[16] = encodeS(3, 10, 24);
  // Load then immediate use
  programImage[17] = encodeI(opcodeLoad, 3'b010, 11, 0, 'h40);
  programImage[18] = encodeR(3'b000, 1'b0, 12, 11, 1);
  programImage[19] = encodeS(12, 10, 28);
  // Two taken branches skip a store each, two fall through
  programImage[20] = encodeB(3'b000, 1, 1, 8);
  programImage[21] = encodeS(1, 10, 32);
  programImage[22] = encodeB(3'b001, 1, 2, 8);
  programImage[23] = encodeS(2, 10, 36);
  programImage[24] = encodeB(3'b000, 1, 2, 8);
  programImage[25] = encodeS(11, 10, 40);
  programImage[26] = encodeB(3'b001, 1, 1, 8);
  programImage[27] = encodeS(12, 10, 44);
  programImage[28] = encodeI(opcodeLoad, 3'b010, 13, 10, 4);
  programImage[29] = encodeS(13, 10, 48);
  programImage[30] = encodeB(3'b000, 0, 0, 0);
endfunction

function automatic logic [31:0] fetchWord(input logic [31:0] address);
  logic [31:0] offset;
  offset = address - resetAddress;
  if (offset < programWords * 4) begin
    return programImage[offset[7:2]];
  end
  return '0;
endfunction

function automatic logic [31:0] initialData(input logic [7:0] index);
  logic [31:0] address;
  address = {22'b0, index, 2'b0};
  return (address * 32'h9E37_79B9) ^ 32'hC0DE_0000 ^ address;
endfunction

// Architectural run in program order, one instruction at a time
function automatic void runModel();
  logic [31:0] regs [0:31];
  logic [31:0] memory [0:dataWords-1];
  logic [31:0] pc;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] result;
  logic [31:0] address;
  instrT instr;
  regs = '{default: '0};
  for (int i = 0; i < dataWords; i++) begin
    memory[i[7:0]] = initialData(i[7:0]);
  end
  expectedAddress.delete();
  expectedData.delete();
  pc = resetAddress;
  for (int step = 0; step < 1000 && fetchWord(pc) != loopWord; step++) begin
    instr = fetchWord(pc);
    a = regs[instr.rType.rs1];
    b = (instr.rType.opcode == opcodeOp) ? regs[instr.rType.rs2] :
        {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
    case (instr.rType.funct3)
      3'b000: result = (instr.rType.opcode == opcodeOp && instr.rType.funct7[5]) ? a - b : a + b;
      3'b010: result = {31'b0, $signed(a) < $signed(b)};
      3'b100: result = a ^ b;
      3'b110: result = a | b;
      default: result = a & b;
    endcase
    case (instr.rType.opcode)
      opcodeOp, opcodeOpImm: regs[instr.rType.rd] = result;
      opcodeLui: regs[instr.rType.rd] = {instr[31:12], 12'b0};
      opcodeLoad: begin
        address = a + b;
        regs[instr.iType.rd] = memory[address[9:2]];
      end
      opcodeStore: begin
        address = a + {{20{instr.sType.immHigh[6]}}, instr.sType.immHigh, instr.sType.immLow};
        memory[address[9:2]] = regs[instr.sType.rs2];
        expectedAddress.push_back(address);
        expectedData.push_back(regs[instr.sType.rs2]);
      end
      opcodeBranch: begin
        if ((a == regs[instr.bType.rs2]) != instr.bType.funct3[0]) begin
          pc = pc - 4 + {{19{instr.bType.immBit12}}, instr.bType.immBit12, instr.bType.immBit11,
                         instr.bType.immHigh, instr.bType.immLow, 1'b0};
        end
      end
      default: begin
      end
    endcase
    regs[0] = '0;
    pc = pc + 4;
  end
endfunction

`endif

/* tests/coreTb.sv */
`default_nettype none
`timescale 1ns/1ns

module coreTb
  import cpuPkg::*;
();

  localparam logic [31:0] resetAddress = 32'h0000_0100;
  localparam logic [31:0] loopAddress = resetAddress + 32'd120;
  localparam int dataWords = 256;
  localparam int cycleLimit = 3000;

  logic clk;
  logic rstN;
  logic [31:0] instrAddress;
  logic [31:0] instrData;
  logic instrReady;
  logic [31:0] dataAddress;
  logic [31:0] dataWriteData;
  logic dataRead;
  logic dataWrite;
  logic [31:0] dataReadData;
  logic dataReady;

  logic [31:0] dataMemory [0:dataWords-1];
  bit randomWaits;
  int instrDelay;
  int dataDelay;
  bit instrWaiting;
  bit dataWaiting;
  logic [31:0] lastInstrAddress;
  bit holdPending;
  logic [31:0] heldAddress;
  logic [31:0] heldData;
  logic heldWrite;
  int errorCount = 0;
  int storeCount = 0;
  int passCount = 0;
  int failCount = 0;

  `include "riscvModel.svh"

  riscvCore #(
    .resetAddress(resetAddress)
  ) dut (
    .clk(clk),
    .rstN(rstN),
    .instrAddress(instrAddress),
    .instrData(instrData),
    .instrReady(instrReady),
    .dataAddress(dataAddress),
    .dataWriteData(dataWriteData),
    .dataRead(dataRead),
    .dataWrite(dataWrite),
    .dataReadData(dataReadData),
    .dataReady(dataReady)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Both memories answer after 0 to 3 cycles when wait states are on
  function automatic void driveInputs();
    if (instrAddress != lastInstrAddress || !instrWaiting) begin
      instrDelay = randomWaits ? $urandom_range(3, 0) : 0;
      instrWaiting = 1'b1;
    end else if (instrDelay != 0) begin
      instrDelay--;
    end
    lastInstrAddress = instrAddress;
    instrReady = instrDelay == 0;
    instrData = fetchWord(instrAddress);
    if (instrReady) begin
      instrWaiting = 1'b0;
    end
    if (dataRead || dataWrite) begin
      if (!dataWaiting) begin
        dataDelay = randomWaits ? $urandom_range(3, 0) : 0;
        dataWaiting = 1'b1;
      end else if (dataDelay != 0) begin
        dataDelay--;
      end
      dataReady = dataDelay == 0;
      if (dataReady) begin
        dataWaiting = 1'b0;
      end
    end else begin
      dataReady = 1'b0;
      dataWaiting = 1'b0;
    end
    dataReadData = dataMemory[dataAddress[9:2]];
  endfunction

  initial begin
    void'($urandom(32'h621d5019));
    forever begin
      @(posedge clk);
      #10;
      driveInputs();
    end
  end

  function automatic void compareStore();
    if (expectedAddress.size() == 0) begin
      $display("Store to address %h arrived with no store left to expect", dataAddress);
      errorCount++;
    end else begin
      assert (dataAddress == expectedAddress[0]) else begin
        $display("[ERROR] dataAddress: got %h, expected %h", dataAddress, expectedAddress[0]);
        errorCount++;
      end
      assert (dataWriteData == expectedData[0]) else begin
        $display("[ERROR] dataWriteData: got %h, expected %h", dataWriteData, expectedData[0]);
        errorCount++;
      end
      void'(expectedAddress.pop_front());
      void'(expectedData.pop_front());
      storeCount++;
    end
  endfunction

  function automatic void checkHeld();
    assert (dataAddress == heldAddress) else begin
      $display("[ERROR] dataAddress: got %h, held %h", dataAddress, heldAddress);
      errorCount++;
    end
    assert ((dataRead || dataWrite) && dataWrite == heldWrite) else begin
      $display("Data request dropped or changed type before dataReady");
      errorCount++;
    end
    if (heldWrite) begin
      assert (dataWriteData == heldData) else begin
        $display("[ERROR] dataWriteData: got %h, held %h", dataWriteData, heldData);
        errorCount++;
      end
    end
  endfunction

  // Outputs are stable at the falling edge; an accepted store lands here
  always @(negedge clk) begin
    if (!rstN) begin
      assert (!dataRead && !dataWrite) else begin
        $display("Data memory request raised during reset");
        errorCount++;
      end
      holdPending = 1'b0;
    end else begin
      if (holdPending) begin
        checkHeld();
      end
      holdPending = (dataRead || dataWrite) && !dataReady;
      heldAddress = dataAddress;
      heldData = dataWriteData;
      heldWrite = dataWrite;
      if (dataWrite && dataReady) begin
        compareStore();
        dataMemory[dataAddress[9:2]] = dataWriteData;
      end
    end
  end

  function automatic void prepareRun(input bit waits);
    randomWaits = waits;
    for (int i = 0; i < dataWords; i++) begin
      dataMemory[i[7:0]] = initialData(i[7:0]);
    end
    runModel();
    storeCount = 0;
  endfunction

  task automatic applyReset();
    @(posedge clk);
    #10;
    rstN = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
    end
    #10;
    rstN = 1'b1;
    @(negedge clk);
    assert (instrAddress == resetAddress) else begin
      $display("[ERROR] instrAddress: got %h, expected %h", instrAddress, resetAddress);
      errorCount++;
    end
  endtask

  function automatic void reportTest(input string name, input int startErrors);
    if (errorCount == startErrors) begin
      $display("Test %s: passed", name);
      passCount++;
    end else begin
      $display("Test %s: failed with %0d errors", name, errorCount - startErrors);
      failCount++;
    end
  endfunction

  task automatic runProgram(input string name, input int startErrors);
    int cycles;
    int expectedCount;
    expectedCount = expectedAddress.size();
    cycles = 0;
    while (storeCount < expectedCount && cycles < cycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (storeCount < expectedCount) begin
      $display("Timed out after %0d cycles with %0d of %0d stores seen", cycles, storeCount,
               expectedCount);
      errorCount++;
    end
    cycles = 0;
    while (instrAddress != loopAddress && cycles < cycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (instrAddress != loopAddress) begin
      $display("Timed out before the core reached its final loop");
      errorCount++;
    end
    reportTest(name, startErrors);
  endtask

  initial begin
    int startErrors;
    rstN = 1'b0;
    instrData = '0;
    instrReady = 1'b0;
    dataReadData = '0;
    dataReady = 1'b0;
    loadProgram();
    startErrors = errorCount;
    prepareRun(1'b0);
    applyReset();
    reportTest("reset", startErrors);
    runProgram("program without wait states", errorCount);
    startErrors = errorCount;
    prepareRun(1'b1);
    applyReset();
    runProgram("program with random wait states", startErrors);
    $display("Summary: %0d tests passed, %0d failed, %0d errors", passCount, failCount,
             errorCount);
    if (failCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
common/cpuPkg.sv
source/registerFile.sv
source/hazardUnit.sv
pipeline/decodeStage.sv
pipeline/executeStage.sv
source/riscvCore.sv
tests/coreTb.sv
